// ==== src/axil_sram_config.svh ====
// Widths and depth are fixed together; DEPTH must equal 2**IDX_W and STRB_W must be DATA_W/8
`ifndef AXIL_SRAM_CONFIG_SVH
`define AXIL_SRAM_CONFIG_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define AXIL_DATA_W 64
`define AXIL_ADDR_W 32
`define AXIL_STRB_W 8

// ----------------------------------------------------------
// Storage
// ----------------------------------------------------------
// 256 words of 8 bytes, a 2 KiB window starting at 0
`define SRAM_DEPTH 256
`define SRAM_IDX_W 8

// ----------------------------------------------------------
// Response codes
// ----------------------------------------------------------
`define AXIL_RESP_OKAY   2'b00
`define AXIL_RESP_SLVERR 2'b10

`endif

// ==== src/axil_sram_pkg.sv ====
// Types only; widths follow the macros in axil_sram_config.svh, which must be on the include path
`default_nettype none

`include "axil_sram_config.svh"

package axil_sram_pkg;

  // Bus payloads
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]              axil_resp_t;

  // Word index into the bank
  typedef logic [`SRAM_IDX_W-1:0]  sram_idx_t;

  // Write channel FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Read channel FSM
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

endpackage

`default_nettype wire

// ==== src/sram_wr_if.sv ====
// Bank write port; one word per cycle, byte lanes gated by strb while en is high
`default_nettype none

interface sram_wr_if;

  import axil_sram_pkg::*;

  logic       en;
  sram_idx_t  idx;
  axil_data_t data;
  axil_strb_t strb;

  // Write controller side
  modport ctrl (
    output en,
    output idx,
    output data,
    output strb
  );

  // Storage side
  modport mem (
    input en,
    input idx,
    input data,
    input strb
  );

endinterface

`default_nettype wire

// ==== src/axil_write_ctrl.sv ====
// One write in flight; out-of-range address gives SLVERR and no bank write, prot ignored
`default_nettype none

`include "axil_sram_config.svh"

module axil_write_ctrl (
  input  wire                       i_aclk,
  input  wire                       i_arst_n,
  input  wire                       i_awvalid,
  output logic                      o_awready,
  input  axil_sram_pkg::axil_addr_t i_awaddr,
  input  wire                       i_wvalid,
  output logic                      o_wready,
  input  axil_sram_pkg::axil_data_t i_wdata,
  input  axil_sram_pkg::axil_strb_t i_wstrb,
  output logic                      o_bvalid,
  input  wire                       i_bready,
  output axil_sram_pkg::axil_resp_t o_bresp,
  sram_wr_if.ctrl                   wr_port
);

  import axil_sram_pkg::*;

  localparam int unsigned IDX_LSB = $clog2(`AXIL_STRB_W);
  localparam int unsigned IDX_MSB = IDX_LSB + `SRAM_IDX_W - 1;

  wr_state_e state_q;
  sram_idx_t idx_q;
  logic      in_range_q;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;
  logic      aw_in_range;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;

  // Upper address bits must all be zero
  assign aw_in_range = (i_awaddr[`AXIL_ADDR_W-1:IDX_MSB+1] == '0);

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= WR_IDLE;
      in_range_q <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (aw_fire) begin
            state_q    <= WR_DATA;
            in_range_q <= aw_in_range;
          end
        end
        WR_DATA: if (w_fire) state_q <= WR_RESP;
        WR_RESP: if (b_fire) state_q <= WR_IDLE;
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  // Word index, taken only on the AW handshake
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      idx_q <= i_awaddr[IDX_MSB:IDX_LSB];
    end
  end

  assign o_awready = (state_q == WR_IDLE);
  assign o_wready  = (state_q == WR_DATA);
  assign o_bvalid  = (state_q == WR_RESP);
  assign o_bresp   = in_range_q ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;

  // Bank write lands on the W handshake edge
  assign wr_port.en   = w_fire & in_range_q;
  assign wr_port.idx  = idx_q;
  assign wr_port.data = i_wdata;
  assign wr_port.strb = i_wstrb;

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_bvalid_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

  // Bank write only in the data state, entered through the AW handshake
  a_write_in_data: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    wr_port.en |-> o_wready && ($past(aw_fire) || $past(o_wready)));

endmodule

`default_nettype wire

// ==== src/axil_read_ctrl.sv ====
// One read in flight; rvalid follows two edges after AR, out-of-range reads return zero
`default_nettype none

`include "axil_sram_config.svh"

module axil_read_ctrl (
  input  wire                       i_aclk,
  input  wire                       i_arst_n,
  input  wire                       i_arvalid,
  output logic                      o_arready,
  input  axil_sram_pkg::axil_addr_t i_araddr,
  input  wire                       i_rready,
  output logic                      o_rvalid,
  output axil_sram_pkg::axil_data_t o_rdata,
  output axil_sram_pkg::axil_resp_t o_rresp,
  output logic                      o_rd_en,
  output axil_sram_pkg::sram_idx_t  o_rd_idx,
  input  axil_sram_pkg::axil_data_t i_rd_word
);

  import axil_sram_pkg::*;

  localparam int unsigned IDX_LSB = $clog2(`AXIL_STRB_W);
  localparam int unsigned IDX_MSB = IDX_LSB + `SRAM_IDX_W - 1;

  rd_state_e  state_q;
  logic       rvalid_q;
  logic       in_range_q;
  axil_data_t rdata_q;
  logic       ar_fire;
  logic       r_fire;

  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= RD_IDLE;
      rvalid_q   <= 1'b0;
      in_range_q <= 1'b0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (ar_fire) begin
            state_q    <= RD_RESP;
            in_range_q <= (i_araddr[`AXIL_ADDR_W-1:IDX_MSB+1] == '0);
          end
        end
        RD_RESP: begin
          // First cycle here waits for the bank word
          if (!rvalid_q) begin
            rvalid_q <= 1'b1;
          end else if (r_fire) begin
            rvalid_q <= 1'b0;
            state_q  <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // Holding register for the returned word
  always_ff @(posedge i_aclk) begin
    if (state_q == RD_RESP && !rvalid_q) begin
      rdata_q <= in_range_q ? i_rd_word : '0;
    end
  end

  assign o_rd_en   = ar_fire;
  assign o_rd_idx  = i_araddr[IDX_MSB:IDX_LSB];
  assign o_arready = (state_q == RD_IDLE);
  assign o_rvalid  = rvalid_q;
  assign o_rdata   = rdata_q;
  assign o_rresp   = in_range_q ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;

  // Payload frozen under back-pressure
  a_r_stable: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

`default_nettype wire

// ==== src/sram_bank.sv ====
// Array has no reset and powers up unknown; a same-cycle read and write to one word reads old data
`default_nettype none

`include "axil_sram_config.svh"

module sram_bank (
  input  wire                       i_aclk,
  sram_wr_if.mem                    wr_port,
  input  wire                       i_rd_en,
  input  axil_sram_pkg::sram_idx_t  i_rd_idx,
  output axil_sram_pkg::axil_data_t o_rd_word
);

  import axil_sram_pkg::*;

  axil_data_t mem [`SRAM_DEPTH];

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (wr_port.en) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (wr_port.strb[b]) begin
          mem[wr_port.idx][b*8 +: 8] <= wr_port.data[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read port
  // ----------------------------------------------------------
  // Output keeps the last word between reads
  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      o_rd_word <= mem[i_rd_idx];
    end
  end

endmodule

`default_nettype wire

// ==== src/axil_sram_top.sv ====
// AXI4-Lite slave with 2 KiB at address 0; no bursts or IDs, awprot and arprot are ignored
`default_nettype none

module axil_sram_top (
  input  wire                       i_aclk,
  input  wire                       i_arst_n,

  // Write address channel
  input  wire                       i_awvalid,
  output logic                      o_awready,
  input  axil_sram_pkg::axil_addr_t i_awaddr,
  input  wire  [2:0]                i_awprot,

  // Write data channel
  input  wire                       i_wvalid,
  output logic                      o_wready,
  input  axil_sram_pkg::axil_data_t i_wdata,
  input  axil_sram_pkg::axil_strb_t i_wstrb,

  // Write response channel
  output logic                      o_bvalid,
  input  wire                       i_bready,
  output axil_sram_pkg::axil_resp_t o_bresp,

  // Read address channel
  input  wire                       i_arvalid,
  output logic                      o_arready,
  input  axil_sram_pkg::axil_addr_t i_araddr,
  input  wire  [2:0]                i_arprot,

  // Read data channel
  output logic                      o_rvalid,
  input  wire                       i_rready,
  output axil_sram_pkg::axil_data_t o_rdata,
  output axil_sram_pkg::axil_resp_t o_rresp
);

  import axil_sram_pkg::*;

  logic       rd_en;
  sram_idx_t  rd_idx;
  axil_data_t rd_word;

  sram_wr_if u_wr_if ();

  // ----------------------------------------------------------
  // Write path
  // ----------------------------------------------------------
  axil_write_ctrl u_write_ctrl (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .wr_port   (u_wr_if.ctrl)
  );

  // Shared storage
  sram_bank u_bank (
    .i_aclk    (i_aclk),
    .wr_port   (u_wr_if.mem),
    .i_rd_en   (rd_en),
    .i_rd_idx  (rd_idx),
    .o_rd_word (rd_word)
  );

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------
  axil_read_ctrl u_read_ctrl (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .i_rready  (i_rready),
    .o_rvalid  (o_rvalid),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rd_en   (rd_en),
    .o_rd_idx  (rd_idx),
    .i_rd_word (rd_word)
  );

  // No access checks on i_awprot and i_arprot

endmodule

`default_nettype wire

// ==== dv/tb_axil_sram.sv ====
// Drives the SRAM slave through the bus only; the memory holds unknown data until the fill pass
`default_nettype none

`include "axil_sram_config.svh"

module tb_axil_sram;

  timeunit 1ns;
  timeprecision 1ps;

  import axil_sram_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DLY   = 10;
  localparam int N_RANDOM    = 200;
  // Fill pass, random write/read pairs, directed accesses
  localparam int N_TRANS     = `SRAM_DEPTH + 2 * N_RANDOM + 40;
  localparam int WATCHDOG_NS = (N_TRANS * 20 + 200) * CLK_PERIOD;

  logic       aclk;
  logic       arst_n;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic [2:0] awprot;
  logic       wvalid;
  logic       wready;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       bvalid;
  logic       bready;
  axil_resp_t bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic [2:0] arprot;
  logic       rvalid;
  logic       rready;
  axil_data_t rdata;
  axil_resp_t rresp;

  axil_data_t  ref_mem [`SRAM_DEPTH];
  logic [31:0] rng_state = 32'hac97;

  axil_sram_top dut (
    .i_aclk    (aclk),
    .i_arst_n  (arst_n),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_awprot  (awprot),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .i_arprot  (arprot),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the DUT stopped answering a handshake");
    $display("Some tests failed");
    $fatal(1, "timeout");
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic report_fail(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "check failed");
  endtask

  // Every drive happens just after a rising edge
  task automatic next_cycle();
    @(posedge aclk);
    #(DRIVE_DLY);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic in_window(input axil_addr_t addr);
    return addr[31:11] == 21'd0;
  endfunction

  function automatic sram_idx_t word_of(input axil_addr_t addr);
    return addr[10:3];
  endfunction

  function automatic axil_data_t merge_bytes(input axil_data_t old, input axil_data_t data,
                                             input axil_strb_t strb);
    axil_data_t res;
    res = old;
    for (int b = 0; b < `AXIL_STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Bus tasks
  // ----------------------------------------------------------
  task automatic reset_dut();
    arst_n  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    awprot  = 3'b000;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arprot  = 3'b000;
    rready  = 1'b0;
    repeat (5) @(posedge aclk);
    #(DRIVE_DLY);
    arst_n = 1'b1;
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int delay,
                            output axil_resp_t resp);
    axil_resp_t held;
    awvalid = 1'b1;
    awaddr  = addr;
    while (!awready) next_cycle();
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    while (!wready) next_cycle();
    next_cycle();
    wvalid = 1'b0;
    while (!bvalid) next_cycle();
    held = bresp;
    // Response must hold while bready is low
    repeat (delay) begin
      next_cycle();
      assert (bvalid && bresp == held)
        else report_fail("bvalid or bresp changed while bready was low");
      assert (!awready) else report_fail("AW accepted while a write response was pending");
    end
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
    assert (!bvalid) else report_fail("bvalid still high after the B transfer");
    resp = held;
  endtask

  task automatic axil_read(input axil_addr_t addr, input int delay,
                           output axil_data_t data, output axil_resp_t resp);
    axil_data_t held_data;
    axil_resp_t held_resp;
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) next_cycle();
    next_cycle();
    arvalid = 1'b0;
    while (!rvalid) next_cycle();
    held_data = rdata;
    held_resp = rresp;
    repeat (delay) begin
      next_cycle();
      assert (rvalid && rdata === held_data && rresp == held_resp)
        else report_fail("rvalid, rdata or rresp changed while rready was low");
      assert (!arready) else report_fail("AR accepted while read data was pending");
    end
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
    assert (!rvalid) else report_fail("rvalid still high after the R transfer");
    data = held_data;
    resp = held_resp;
  endtask

  // Checked accesses against the reference model
  task automatic write_checked(input axil_addr_t addr, input axil_data_t data,
                               input axil_strb_t strb, input int delay);
    axil_resp_t resp;
    axil_resp_t exp;
    exp = in_window(addr) ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
    axil_write(addr, data, strb, delay, resp);
    assert (resp == exp)
      else report_fail($sformatf("write 0x%h: bresp %0d, expected %0d", addr, resp, exp));
    if (in_window(addr)) begin
      ref_mem[word_of(addr)] = merge_bytes(ref_mem[word_of(addr)], data, strb);
    end
  endtask

  task automatic read_checked(input axil_addr_t addr, input int delay);
    axil_data_t data;
    axil_resp_t resp;
    axil_data_t exp_data;
    axil_resp_t exp_resp;
    exp_data = in_window(addr) ? ref_mem[word_of(addr)] : '0;
    exp_resp = in_window(addr) ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
    axil_read(addr, delay, data, resp);
    assert (resp == exp_resp)
      else report_fail($sformatf("read 0x%h: rresp %0d, expected %0d", addr, resp, exp_resp));
    assert (data === exp_data)
      else report_fail($sformatf("read 0x%h: got %h, expected %h", addr, data, exp_data));
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    next_cycle();
    assert (awready && arready && !wready && !bvalid && !rvalid)
      else report_fail("handshake outputs not at their reset values");
  endtask

  // Pattern depends on every address bit
  task automatic fill_memory();
    axil_addr_t addr;
    for (int i = 0; i < `SRAM_DEPTH; i++) begin
      addr = {21'd0, i[7:0], 3'b000};
      write_checked(addr, {addr * 32'h9e37_79b1, ~addr}, 8'hff, 0);
    end
  endtask

  task automatic test_write_read();
    write_checked(32'h0000_0100, 64'h0123_4567_89ab_cdef, 8'hff, 0);
    read_checked(32'h0000_0100, 0);
    write_checked(32'h0000_07f8, 64'hfedc_ba98_7654_3210, 8'hff, 0);
    read_checked(32'h0000_0100, 0);
    read_checked(32'h0000_07f8, 0);
  endtask

  task automatic test_partial_strobe();
    axil_strb_t strbs [4] = '{8'h01, 8'ha5, 8'hf0, 8'h80};
    axil_data_t datas [4] = '{64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888,
                              64'h9999_aaaa_bbbb_cccc, 64'hdddd_eeee_ffff_0000};
    for (int k = 0; k < 4; k++) begin
      write_checked(32'h0000_0230, datas[k], strbs[k], 0);
      read_checked(32'h0000_0230, 0);
    end
  endtask

  task automatic test_out_of_range();
    axil_addr_t bad [3] = '{32'h0000_0840, 32'h8000_0040, 32'h0010_0048};
    for (int k = 0; k < 3; k++) begin
      write_checked(bad[k], 64'hbad0_bad0_bad0_bad0, 8'hff, 0);
      read_checked(bad[k], 0);
      read_checked(bad[k] & 32'h0000_07ff, 0);
    end
  endtask

  task automatic test_back_pressure();
    write_checked(32'h0000_0318, 64'hdead_beef_cafe_f00d, 8'hff, 6);
    read_checked(32'h0000_0318, 6);
    write_checked(32'h0000_1318, 64'h0bad_0bad_0bad_0bad, 8'hff, 5);
    read_checked(32'h0000_1318, 5);
  endtask

  task automatic test_random();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    axil_addr_t  addr;
    axil_addr_t  rd_addr;
    for (int n = 0; n < N_RANDOM; n++) begin
      r0   = next_rand();
      r1   = next_rand();
      r2   = next_rand();
      addr = {21'd0, r0[10:0]};
      write_checked(addr, {r1, r2}, r0[18:11], int'(r0[20:19]));
      r0      = next_rand();
      rd_addr = r0[31] ? addr : {21'd0, r0[10:0]};
      read_checked(rd_addr, int'(r0[13:12]));
    end
  endtask

  initial begin
    reset_dut();
    test_reset_state();
    fill_memory();
    test_write_read();
    test_partial_strobe();
    test_out_of_range();
    test_back_pressure();
    test_random();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/axil_sram_pkg.sv
src/sram_wr_if.sv
src/axil_write_ctrl.sv
src/axil_read_ctrl.sv
src/sram_bank.sv
src/axil_sram_top.sv
dv/tb_axil_sram.sv

// ==== run.sh ====
#!/bin/sh
# Builds the AXI4-Lite SRAM testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert -j 0 \
  -f files.f \
  --top-module tb_axil_sram \
  -Mdir "$BUILD_DIR/obj_dir" \
  -o tb_axil_sram

# Result is taken from the log below
"$BUILD_DIR/obj_dir/tb_axil_sram" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "All tests passed" "$LOG"; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
